// ==== am_pkg.sv ====
package am_pkg;

	// 64b/66b block geometry
	localparam int AM_HEAD_W = 2;
	localparam int AM_DATA_W = 64;
	localparam int AM_BLOCK_W = AM_HEAD_W + AM_DATA_W;

	// width of one byte of the data field and of the BIP fields
	localparam int AM_BYTE_W = 8;
	localparam int AM_BIP_W = 8;

	// number of lanes that have a marker row in the table below
	localparam int AM_LANE_MAX = 4;

	// markers are sent as control blocks
	localparam logic [AM_HEAD_W-1:0] AM_SYNC_CTRL = 2'b10;

	// byte positions of the parity fields inside the marker data field
	localparam int AM_BIP3_BYTE = 3;
	localparam int AM_BIP7_BYTE = 7;

	// six fixed bytes per lane go into the remaining byte positions
	localparam int AM_MARK_N = 6;
	localparam int AM_MARK_POS [AM_MARK_N] = '{0, 1, 2, 4, 5, 6};

	// per lane marker bytes M0, M1, M2, M4, M5, M6 in send order
	// byte 0 lands in data bits 7:0
	localparam logic [7:0] am_marker_bytes [AM_LANE_MAX][AM_MARK_N] = '{
		'{8'h90, 8'h76, 8'h47, 8'h6f, 8'h89, 8'hb8},
		'{8'hf0, 8'hc4, 8'he6, 8'h0f, 8'h3b, 8'h19},
		'{8'hc5, 8'h65, 8'h9b, 8'h3a, 8'h9a, 8'h64},
		'{8'ha2, 8'h79, 8'h3d, 8'h5d, 8'h86, 8'hc2}
	};

endpackage

// ==== am_ctrl.sv ====
`timescale 1ns/1ps

// marker slot timing shared by all lanes
// the strobe is high in the first cycle after reset and then once
// every 2^GAP_W cycles, when the block counter wraps
module am_ctrl #(
	parameter int GAP_W = 14
)(
	input  logic clk,
	input  logic nreset,
	output logic am_v_o
);

	// number of block periods since the last marker slot
	logic [GAP_W-1:0] gap_q;
	logic [GAP_W-1:0] gap_inc;
	logic             gap_ovf;

	// registered marker slot strobe
	logic am_v_q;
	logic am_v_next;

	// one extra bit catches the wrap of the counter
	always_comb begin
		{gap_ovf, gap_inc} = {1'b0, gap_q} + {{GAP_W{1'b0}}, 1'b1};
	end

	// a new slot opens in the cycle after the counter reaches all ones
	assign am_v_next = gap_ovf;

	always_ff @(posedge clk) begin
		if (~nreset) begin
			gap_q <= '0;
		end else begin
			// the counter runs freely, so the wrap itself sets the period
			gap_q <= gap_inc;
		end
	end

	always_ff @(posedge clk) begin
		if (~nreset) begin
			// the first block after reset is always a marker
			am_v_q <= 1'b1;
		end else begin
			am_v_q <= am_v_next;
		end
	end

	assign am_v_o = am_v_q;

endmodule

// ==== am_bip.sv ====
`timescale 1ns/1ps

// bit interleaved parity over the blocks a lane has sent
// bit j of the parity is the xor of every block bit whose index
// is j modulo 8, with the sync header at index 0 and 1
module am_bip import am_pkg::*; (
	input  logic                  clk,
	input  logic                  nreset,
	input  logic [AM_BLOCK_W-1:0] block_i,
	input  logic                  block_v_i,
	input  logic                  am_v_i,
	output logic [AM_BIP_W-1:0]   bip3_o
);

	// parity of the block currently on the lane output
	logic [AM_BIP_W-1:0] blk_par;
	logic [AM_BIP_W-1:0] cur_par;

	// parity of the blocks that already left the output register
	logic [AM_BIP_W-1:0] acc_q;

	always_comb begin
		blk_par = '0;
		for (int k = 0; k < AM_BLOCK_W; k++) begin
			blk_par[k % AM_BIP_W] = blk_par[k % AM_BIP_W] ^ block_i[k];
		end
	end

	// the output register holds zero until the first block after reset
	assign cur_par = block_v_i ? blk_par : '0;

	// running parity up to and including the block now on the output
	// this is what a marker registered at the next edge must carry
	assign bip3_o = acc_q ^ cur_par;

	always_ff @(posedge clk) begin
		if (~nreset) begin
			acc_q <= '0;
		end else if (am_v_i) begin
			// a marker is being registered, so the count starts over
			// the marker itself gets folded in one edge later, when it
			// sits on the output, which leaves its own parity alone
			acc_q <= '0;
		end else begin
			acc_q <= acc_q ^ cur_par;
		end
	end

endmodule

// ==== am_lane_tx.sv ====
`timescale 1ns/1ps

// one lane of the marker stage
// in a marker slot the lane sends its own marker block, otherwise
// it forwards the input block, with one cycle of latency either way
module am_lane_tx import am_pkg::*; #(
	parameter int LANE_ID = 0
)(
	input  logic                 clk,
	input  logic                 nreset,
	input  logic                 am_v_i,
	input  logic [AM_HEAD_W-1:0] head_i,
	input  logic [AM_DATA_W-1:0] data_i,
	output logic [AM_HEAD_W-1:0] head_o,
	output logic [AM_DATA_W-1:0] data_o
);

	// parity of everything sent since the previous marker
	logic [AM_BIP_W-1:0] bip3;

	// data field of this lane's marker block
	logic [AM_DATA_W-1:0] am_data;

	// block selected for the output register
	logic [AM_HEAD_W-1:0] head_next;
	logic [AM_DATA_W-1:0] data_next;

	// lane output register and its valid flag
	logic [AM_HEAD_W-1:0] head_q;
	logic [AM_DATA_W-1:0] data_q;
	logic                 out_v_q;

	// marker layout is M0 M1 M2 BIP3 M4 M5 M6 BIP7 from byte 0 up
	always_comb begin
		am_data = '0;
		for (int i = 0; i < AM_MARK_N; i++) begin
			am_data[AM_BYTE_W*AM_MARK_POS[i] +: AM_BYTE_W] = am_marker_bytes[LANE_ID][i];
		end
		am_data[AM_BYTE_W*AM_BIP3_BYTE +: AM_BYTE_W] = bip3;
		// BIP7 is simply the complement of BIP3
		am_data[AM_BYTE_W*AM_BIP7_BYTE +: AM_BYTE_W] = ~bip3;
	end

	// input block is dropped in a marker slot
	assign head_next = am_v_i ? AM_SYNC_CTRL : head_i;
	assign data_next = am_v_i ? am_data : data_i;

	always_ff @(posedge clk) begin
		if (~nreset) begin
			head_q  <= '0;
			data_q  <= '0;
			out_v_q <= 1'b0;
		end else begin
			head_q  <= head_next;
			data_q  <= data_next;
			out_v_q <= 1'b1;
		end
	end

	// the parity is taken over what actually leaves the lane
	am_bip m_bip (
		.clk       (clk),
		.nreset    (nreset),
		.block_i   ({data_q, head_q}),
		.block_v_i (out_v_q),
		.am_v_i    (am_v_i),
		.bip3_o    (bip3)
	);

	assign head_o = head_q;
	assign data_o = data_q;

endmodule

// ==== pcs_am_tx.sv ====
`timescale 1ns/1ps

// transmit side alignment marker insertion for LANE_N pcs lanes
// lane i uses slice i of every lane vector
module pcs_am_tx import am_pkg::*; #(
	parameter int LANE_N = 4,
	parameter int GAP_W  = 14
)(
	input  logic                        clk,
	input  logic                        nreset,

	input  logic [LANE_N*AM_HEAD_W-1:0] head_i,
	input  logic [LANE_N*AM_DATA_W-1:0] data_i,

	output logic [LANE_N*AM_HEAD_W-1:0] head_o,
	output logic [LANE_N*AM_DATA_W-1:0] data_o,

	// high in the cycle whose input blocks are not taken
	output logic                        am_slot_o
);

	// marker slot strobe seen by every lane
	logic am_v;

	am_ctrl #(
		.GAP_W (GAP_W)
	) m_ctrl (
		.clk    (clk),
		.nreset (nreset),
		.am_v_o (am_v)
	);

	// upstream has to hold its blocks for one cycle when this is high
	assign am_slot_o = am_v;

	// each lane picks its marker row from its position in the vector
	genvar i;
	generate
		for (i = 0; i < LANE_N; i++) begin : g_lane
			am_lane_tx #(
				.LANE_ID (i)
			) m_lane (
				.clk    (clk),
				.nreset (nreset),
				.am_v_i (am_v),
				.head_i (head_i[i*AM_HEAD_W +: AM_HEAD_W]),
				.data_i (data_i[i*AM_DATA_W +: AM_DATA_W]),
				.head_o (head_o[i*AM_HEAD_W +: AM_HEAD_W]),
				.data_o (data_o[i*AM_DATA_W +: AM_DATA_W])
			);
		end
	endgenerate

endmodule

// ==== pcs_am_tx_asserts.sv ====
`timescale 1ns/1ps

// output checks for the marker stage that are bound into pcs_am_tx
// a per lane parity model follows the blocks that leave each lane
module pcs_am_tx_asserts import am_pkg::*; #(
	parameter int LANE_N = 4,
	parameter int GAP_W  = 14
)(
	input logic                        clk,
	input logic                        nreset,
	input logic [LANE_N*AM_HEAD_W-1:0] head_in_i,
	input logic [LANE_N*AM_DATA_W-1:0] data_in_i,
	input logic [LANE_N*AM_HEAD_W-1:0] head_out_i,
	input logic [LANE_N*AM_DATA_W-1:0] data_out_i,
	input logic                        am_slot_i
);

	// distance between two marker slots in cycles
	localparam logic [GAP_W:0] PERIOD = {1'b1, {GAP_W{1'b0}}};

	// every byte of a marker except BIP3 and BIP7
	localparam logic [63:0] FIXED_MASK = 64'h00ff_ffff_00ff_ffff;

	int errors = 0;

	// what the previous rising edge saw
	logic                        was_reset = 1'b0;
	logic                        live_d = 1'b0;
	logic                        slot_d = 1'b0;
	logic [LANE_N*AM_HEAD_W-1:0] head_d;
	logic [LANE_N*AM_DATA_W-1:0] data_d;

	// cycles since the last marker slot
	// the count stays at all ones once slots stop
	logic [GAP_W:0] since_slot;

	// parity of the blocks a lane sent since its previous marker
	// that marker is part of the count
	logic [LANE_N-1:0][7:0] bip_model;

	// bit j collects block indices j, j+8, j+16 ... with the header at 0 and 1
	function automatic logic [7:0] block_parity(input logic [AM_HEAD_W-1:0] head,
		input logic [AM_DATA_W-1:0] data);
		logic [AM_BLOCK_W-1:0] blk;
		logic [7:0]            par;
		blk = {data, head};
		par = '0;
		for (int j = 0; j < 8; j++) begin
			for (int k = j; k < AM_BLOCK_W; k += 8) begin
				par[j] = par[j] ^ blk[k];
			end
		end
		return par;
	endfunction

	// fixed marker bytes M0 M1 M2 at bytes 0 to 2 and M4 M5 M6 at bytes 4 to 6
	function automatic logic [63:0] marker_fixed(input int lane);
		logic [63:0] m;
		m = '0;
		m[7:0]   = am_marker_bytes[lane][0];
		m[15:8]  = am_marker_bytes[lane][1];
		m[23:16] = am_marker_bytes[lane][2];
		m[39:32] = am_marker_bytes[lane][3];
		m[47:40] = am_marker_bytes[lane][4];
		m[55:48] = am_marker_bytes[lane][5];
		return m;
	endfunction

	always @(posedge clk) begin
		was_reset <= ~nreset;
		live_d    <= nreset;
		slot_d    <= am_slot_i;
		head_d    <= head_in_i;
		data_d    <= data_in_i;

		if (~nreset) begin
			since_slot <= '0;
		end else if (am_slot_i) begin
			since_slot <= {{GAP_W{1'b0}}, 1'b1};
		end else if (since_slot != '1) begin
			since_slot <= since_slot + 1'b1;
		end

		// a marker on the output restarts the count with its own parity
		for (int l = 0; l < LANE_N; l++) begin
			if (~nreset) begin
				bip_model[l] <= '0;
			end else if (slot_d) begin
				bip_model[l] <= block_parity(head_out_i[l*AM_HEAD_W +: AM_HEAD_W],
					data_out_i[l*AM_DATA_W +: AM_DATA_W]);
			end else begin
				bip_model[l] <= bip_model[l] ^ block_parity(
					head_out_i[l*AM_HEAD_W +: AM_HEAD_W],
					data_out_i[l*AM_DATA_W +: AM_DATA_W]);
			end
		end
	end

	first_slot_a: assert property (@(posedge clk) disable iff (~nreset)
		~live_d |-> am_slot_i)
	else begin
		$error("mismatch first_slot: expected 1, actual %b", $sampled(am_slot_i));
		errors++;
	end

	slot_period_a: assert property (@(posedge clk) disable iff (~nreset)
		live_d && am_slot_i |-> since_slot == PERIOD)
	else begin
		$error("mismatch slot_period: expected %0d, actual %0d", PERIOD, $sampled(since_slot));
		errors++;
	end

	slot_missing_a: assert property (@(posedge clk) disable iff (~nreset)
		~am_slot_i |-> since_slot < PERIOD)
	else begin
		$error("no marker slot within %0d cycles of the previous one", PERIOD);
		errors++;
	end

	genvar l;
	generate
		for (l = 0; l < LANE_N; l++) begin : g_lane
			logic [AM_HEAD_W-1:0] out_head;
			logic [AM_DATA_W-1:0] out_data;
			logic [AM_HEAD_W-1:0] in_head_d;
			logic [AM_DATA_W-1:0] in_data_d;
			logic [AM_DATA_W-1:0] exp_fixed;

			assign out_head  = head_out_i[l*AM_HEAD_W +: AM_HEAD_W];
			assign out_data  = data_out_i[l*AM_DATA_W +: AM_DATA_W];
			assign in_head_d = head_d[l*AM_HEAD_W +: AM_HEAD_W];
			assign in_data_d = data_d[l*AM_DATA_W +: AM_DATA_W];
			assign exp_fixed = marker_fixed(l);

			forward_a: assert property (@(posedge clk) disable iff (~nreset)
				live_d && ~slot_d |-> out_head == in_head_d && out_data == in_data_d)
			else begin
				$error("mismatch forward lane %0d: expected %h %h, actual %h %h", l,
					$sampled(in_head_d), $sampled(in_data_d),
					$sampled(out_head), $sampled(out_data));
				errors++;
			end

			am_head_a: assert property (@(posedge clk) disable iff (~nreset)
				live_d && slot_d |-> out_head == AM_SYNC_CTRL)
			else begin
				$error("mismatch am_head lane %0d: expected %b, actual %b", l,
					AM_SYNC_CTRL, $sampled(out_head));
				errors++;
			end

			am_fixed_a: assert property (@(posedge clk) disable iff (~nreset)
				live_d && slot_d |-> (out_data & FIXED_MASK) == exp_fixed)
			else begin
				$error("mismatch am_fixed lane %0d: expected %h, actual %h", l,
					exp_fixed, $sampled(out_data & FIXED_MASK));
				errors++;
			end

			am_bip3_a: assert property (@(posedge clk) disable iff (~nreset)
				live_d && slot_d |-> out_data[31:24] == bip_model[l])
			else begin
				$error("mismatch am_bip3 lane %0d: expected %h, actual %h", l,
					$sampled(bip_model[l]), $sampled(out_data[31:24]));
				errors++;
			end

			am_bip7_a: assert property (@(posedge clk) disable iff (~nreset)
				live_d && slot_d |-> out_data[63:56] == ~bip_model[l])
			else begin
				$error("mismatch am_bip7 lane %0d: expected %h, actual %h", l,
					$sampled(~bip_model[l]), $sampled(out_data[63:56]));
				errors++;
			end

			// the outputs must read zero in every cycle that follows a reset edge
			reset_zero_a: assert property (@(posedge clk)
				was_reset |-> out_head == '0 && out_data == '0)
			else begin
				$error("mismatch reset_zero lane %0d: expected 0, actual %h %h", l,
					$sampled(out_head), $sampled(out_data));
				errors++;
			end
		end
	endgenerate

endmodule

bind pcs_am_tx pcs_am_tx_asserts #(
	.LANE_N (LANE_N),
	.GAP_W  (GAP_W)
) m_asserts (
	.clk        (clk),
	.nreset     (nreset),
	.head_in_i  (head_i),
	.data_in_i  (data_i),
	.head_out_i (head_o),
	.data_out_i (data_o),
	.am_slot_i  (am_slot_o)
);

// ==== tb_pcs_am_tx.sv ====
`timescale 1ns/1ps

// testbench for the marker stage with four lanes and a short marker period
// the bound assertion module checks the outputs while this module drives
// random blocks, resets the DUT twice and follows the marker slots
module tb_pcs_am_tx import am_pkg::*; ();

	localparam int LANE_N       = 4;
	localparam int GAP_W        = 6;
	localparam int PERIOD       = 1 << GAP_W;
	localparam int SLOT_TIMEOUT = 4 * PERIOD;
	localparam int CLK_HALF     = 20;
	localparam int RESET_CYCLES = 4;

	logic                        clk;
	logic                        nreset;
	logic [LANE_N*AM_HEAD_W-1:0] head_in;
	logic [LANE_N*AM_DATA_W-1:0] data_in;
	logic [LANE_N*AM_HEAD_W-1:0] head_out;
	logic [LANE_N*AM_DATA_W-1:0] data_out;
	logic                        am_slot;

	// random state and run bookkeeping
	int seed;
	int timeouts;
	int slots_seen;

	pcs_am_tx #(
		.LANE_N (LANE_N),
		.GAP_W  (GAP_W)
	) uut (
		.clk       (clk),
		.nreset    (nreset),
		.head_i    (head_in),
		.data_i    (data_in),
		.head_o    (head_out),
		.data_o    (data_out),
		.am_slot_o (am_slot)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#CLK_HALF clk = ~clk;
		end
	end

	// fresh blocks on every lane, with data and control headers mixed
	task automatic drive_random_blocks();
		int pick;
		for (int l = 0; l < LANE_N; l++) begin
			pick = $random(seed);
			head_in[l*AM_HEAD_W +: AM_HEAD_W] = pick[0] ? 2'b10 : 2'b01;
			data_in[l*AM_DATA_W +: 32] = $random(seed);
			data_in[l*AM_DATA_W+32 +: 32] = $random(seed);
		end
	endtask

	// nreset stays low for the given number of rising edges
	// and is released 1 ns after the last one
	task automatic hold_reset(input int cycles);
		nreset = 1'b0;
		repeat (cycles) @(posedge clk);
		#1;
		nreset = 1'b1;
	endtask

	// looks for the next marker slot at falling edges where am_slot is stable
	task automatic wait_slot();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (am_slot !== 1'b1 && cycles < SLOT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (am_slot === 1'b1) begin
			slots_seen++;
		end else begin
			timeouts++;
			$display("timeout waiting for marker slot");
		end
	endtask

	// upstream does not hold its blocks in a slot cycle
	// the block offered in a slot cycle is simply lost
	always @(posedge clk) begin
		#1;
		drive_random_blocks();
	end

	initial begin
		seed       = 32'h374f_d311;
		timeouts   = 0;
		slots_seen = 0;
		nreset     = 1'b0;
		head_in    = '0;
		data_in    = '0;

		hold_reset(RESET_CYCLES);

		// the first slot comes right after reset, then four full periods
		repeat (5) begin
			wait_slot();
		end

		// second reset lands halfway through a period
		repeat (PERIOD / 2) @(posedge clk);
		#1;
		hold_reset(RESET_CYCLES);

		// first slot after the reset, then two more periods
		repeat (3) begin
			wait_slot();
		end

		// the last marker still has to reach the output register
		repeat (4) @(posedge clk);

		$display("assertion errors: %0d, timeouts: %0d, marker slots seen: %0d",
			uut.m_asserts.errors, timeouts, slots_seen);
		if (uut.m_asserts.errors == 0 && timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
am_pkg.sv
am_ctrl.sv
am_bip.sv
am_lane_tx.sv
pcs_am_tx.sv
pcs_am_tx_asserts.sv
tb_pcs_am_tx.sv

// ==== Makefile ====
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert
TOP       ?= tb_pcs_am_tx
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
RUN_ARGS  ?= +verilator+error+limit+1000
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
